// File: logic/prf_macros.svh
// Sizing macros for the register-file operand path.
// Included by every RTL file that needs a width, a count or a depth.
// The package pulls it in too, so include it before the package compiles.

`ifndef PRF_MACROS_SVH
`define PRF_MACROS_SVH

// ----------------------------------------------------------
// datapath
// ----------------------------------------------------------
`define PRF_XLEN         32  // word width
`define PRF_PHY_REG_NUM  32  // physical registers
`define PRF_TAG_W        5   // log2 of register count

// ----------------------------------------------------------
// ports and lanes
// ----------------------------------------------------------
`define PRF_CDB_NUM      2   // port 0 exec result, port 1 preload
`define PRF_IS_NUM       1   // single issue lane
`define PRF_ZERO_REG     0   // hard-wired zero

// operand queue, power of two
`define PRF_QUEUE_DEPTH  4

`endif

// File: logic/prf_pkg.sv
// Shared types for the operand path.
// Holds the opcode enum and the structs that travel between the
// register file, the fetch stage, the queue and the execute unit.
// Import with prf_pkg::* in the module header.

`default_nettype none

`include "prf_macros.svh"

package prf_pkg;

  // integer ops, 2-bit encoding
  typedef enum logic [1:0] {
    OP_ADD = 2'b00,
    OP_SUB = 2'b01,
    OP_AND = 2'b10,
    OP_XOR = 2'b11
  } alu_op_e;

  // read request, one lane, two sources
  typedef struct packed {
    logic [`PRF_TAG_W-1:0] rd_addr1;  // source a
    logic [`PRF_TAG_W-1:0] rd_addr2;  // source b
  } prf_rd_req_t;

  // read response, same order as the request
  typedef struct packed {
    logic [`PRF_XLEN-1:0] data_out1;
    logic [`PRF_XLEN-1:0] data_out2;
  } prf_rd_rsp_t;

  // one common data bus write
  typedef struct packed {
    logic                  wr_en;
    logic [`PRF_TAG_W-1:0] wr_addr;
    logic [`PRF_XLEN-1:0]  data_in;
  } cdb_wr_t;

  // operands already read, ready to execute
  typedef struct packed {
    alu_op_e               op;
    logic [`PRF_TAG_W-1:0] dest;
    logic [`PRF_XLEN-1:0]  src_a;
    logic [`PRF_XLEN-1:0]  src_b;
  } operand_pkt_t;

endpackage

`default_nettype wire

// File: logic/op_if.sv
// Operand packet link with a four-phase req/ack handshake.
// Sender holds pkt and raises req, receiver captures and raises ack,
// sender drops req, receiver drops ack. A new req waits for ack low.

`timescale 1ns/1ps
`default_nettype none

interface op_if import prf_pkg::*; ();

  logic         req;  // from sender
  logic         ack;  // from receiver
  operand_pkt_t pkt;  // stable while req high

  // ----------------------------------------------------------
  // views
  // ----------------------------------------------------------
  modport sender (
    output req,
    output pkt,
    input  ack
  );

  modport receiver (
    input  req,
    input  pkt,
    output ack
  );

endinterface

`default_nettype wire

// File: logic/prf_regfile.sv
// Physical register file with CDB write ports.
// Reads are combinational and see a same-cycle CDB write through
// forwarding; writes land on the next rising edge. Register 0 always
// reads as zero. When two ports write one address, the higher port wins.

`timescale 1ns/1ps
`default_nettype none

`include "prf_macros.svh"

module prf_regfile import prf_pkg::*; (
  input  wire logic                          clk_i,
  input  wire logic                          rst_i,
  input  wire prf_rd_req_t                   rd_req_i,  // two source tags
  output prf_rd_rsp_t                        rd_rsp_o,  // two operand words
  input  wire cdb_wr_t [`PRF_CDB_NUM-1:0]    cdb_i      // all write ports
);

  logic [`PRF_XLEN-1:0]    regs_q [`PRF_PHY_REG_NUM];
  logic [`PRF_CDB_NUM-1:0] hit_a;  // source a vs each cdb port
  logic [`PRF_CDB_NUM-1:0] hit_b;  // source b vs each cdb port

  // ----------------------------------------------------------
  // hit detection
  // ----------------------------------------------------------
  always_comb begin
    for (int w = 0; w < `PRF_CDB_NUM; w++) begin
      hit_a[w] = cdb_i[w].wr_en && (cdb_i[w].wr_addr == rd_req_i.rd_addr1);
      hit_b[w] = cdb_i[w].wr_en && (cdb_i[w].wr_addr == rd_req_i.rd_addr2);
    end
  end

  // one read port: array value, then forwarded data, then zero override
  function automatic logic [`PRF_XLEN-1:0] read_word(
    input logic [`PRF_TAG_W-1:0]   addr,
    input logic [`PRF_CDB_NUM-1:0] hit
  );
    logic [`PRF_XLEN-1:0] word;
    word = regs_q[addr];
    for (int w = 0; w < `PRF_CDB_NUM; w++) begin
      if (hit[w]) begin
        word = cdb_i[w].data_in;  // later port overrides earlier
      end
    end
    if (addr == `PRF_TAG_W'(`PRF_ZERO_REG)) begin
      word = '0;
    end
    return word;
  endfunction

  // ----------------------------------------------------------
  // read ports
  // ----------------------------------------------------------
  always_comb begin
    rd_rsp_o.data_out1 = read_word(rd_req_i.rd_addr1, hit_a);
    rd_rsp_o.data_out2 = read_word(rd_req_i.rd_addr2, hit_b);
  end

  // ----------------------------------------------------------
  // write ports
  // ----------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int r = 0; r < `PRF_PHY_REG_NUM; r++) begin
        regs_q[r] <= '0;
      end
    end else begin
      // ascending loop, so port 1 lands last on a shared address
      for (int w = 0; w < `PRF_CDB_NUM; w++) begin
        if (cdb_i[w].wr_en && (cdb_i[w].wr_addr != `PRF_TAG_W'(`PRF_ZERO_REG))) begin
          regs_q[cdb_i[w].wr_addr] <= cdb_i[w].data_in;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/operand_fetch.sv
// Operand fetch stage, the producer of the operand path.
// Accepts one issue request at a time, reads both sources from the
// register file in the accept cycle and launches the packet on out.
// A new request is not acked until the previous packet has left.

`timescale 1ns/1ps
`default_nettype none

`include "prf_macros.svh"

module operand_fetch import prf_pkg::*; (
  input  wire logic                   clk_i,
  input  wire logic                   rst_i,
  input  wire logic                   issue_req_i,
  output logic                        issue_ack_o,
  input  wire alu_op_e                issue_op_i,
  input  wire logic [`PRF_TAG_W-1:0]  issue_dest_i,
  input  wire logic [`PRF_TAG_W-1:0]  issue_src_a_i,
  input  wire logic [`PRF_TAG_W-1:0]  issue_src_b_i,
  output prf_rd_req_t                 rd_req_o,
  input  wire prf_rd_rsp_t            rd_rsp_i,
  op_if.sender                        out
);

  typedef enum logic [1:0] {
    F_IDLE,       // waiting for issue
    F_LAUNCH,     // packet held, req rises next edge
    F_WAIT_ACK,   // req high
    F_WAIT_DROP   // req low, waiting for ack low
  } fetch_state_e;

  fetch_state_e state_q;
  logic         issue_ack_q;
  logic         out_req_q;
  operand_pkt_t pkt_q;      // payload, no reset
  logic         accept;

  // sources go straight to the register file
  assign rd_req_o.rd_addr1 = issue_src_a_i;
  assign rd_req_o.rd_addr2 = issue_src_b_i;

  assign accept = (state_q == F_IDLE) && issue_req_i && !issue_ack_q;

  // ----------------------------------------------------------
  // handshake fsm
  // ----------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q     <= F_IDLE;
      issue_ack_q <= 1'b0;
      out_req_q   <= 1'b0;
    end else begin
      if (issue_ack_q && !issue_req_i) begin
        issue_ack_q <= 1'b0;            // issue side phase 4
      end
      unique case (state_q)
        F_IDLE: begin
          if (accept) begin
            issue_ack_q <= 1'b1;
            state_q     <= F_LAUNCH;
          end
        end
        F_LAUNCH: begin
          out_req_q <= 1'b1;
          state_q   <= F_WAIT_ACK;
        end
        F_WAIT_ACK: begin
          if (out.ack) begin
            out_req_q <= 1'b0;          // downstream phase 3
            state_q   <= F_WAIT_DROP;
          end
        end
        F_WAIT_DROP: begin
          // both sides closed before the next issue
          if (!out.ack && !issue_ack_q) begin
            state_q <= F_IDLE;
          end
        end
        default: state_q <= F_IDLE;
      endcase
    end
  end

  // operands frozen at accept, later writes cannot touch them
  always_ff @(posedge clk_i) begin
    if (accept) begin
      pkt_q.op    <= issue_op_i;
      pkt_q.dest  <= issue_dest_i;
      pkt_q.src_a <= rd_rsp_i.data_out1;
      pkt_q.src_b <= rd_rsp_i.data_out2;
    end
  end

  assign issue_ack_o = issue_ack_q;
  assign out.req     = out_req_q;
  assign out.pkt     = pkt_q;

endmodule

`default_nettype wire

// File: logic/operand_queue.sv
// In-order buffer of operand packets between fetch and execute.
// Circular buffer with read/write pointers and an entry count.
// Input side acks one cycle after req unless full; output side offers
// the head entry whenever not empty and pops on the fall of ack.

`timescale 1ns/1ps
`default_nettype none

`include "prf_macros.svh"

module operand_queue import prf_pkg::*; #(
  parameter int DEPTH = `PRF_QUEUE_DEPTH  // power of two
) (
  input  wire logic clk_i,
  input  wire logic rst_i,
  op_if.receiver    in,
  op_if.sender      out
);

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  typedef enum logic [1:0] {
    O_IDLE,  // nothing offered
    O_REQ,   // head offered, req high
    O_DROP   // req dropped, waiting for ack low
  } out_state_e;

  operand_pkt_t     mem_q [DEPTH];  // storage, no reset
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             in_ack_q;
  logic             out_req_q;
  out_state_e       out_state_q;
  logic             full;
  logic             empty;
  logic             push;
  logic             pop;

  assign full  = (count_q == CNT_W'(DEPTH));
  assign empty = (count_q == '0);

  // ----------------------------------------------------------
  // input side
  // ----------------------------------------------------------
  assign push = in.req && !in_ack_q && !full;  // phase 1 seen, room left

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      in_ack_q <= 1'b0;
    end else if (push) begin
      in_ack_q <= 1'b1;
    end else if (in_ack_q && !in.req) begin
      in_ack_q <= 1'b0;                         // phase 4
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= in.pkt;
    end
  end

  // ----------------------------------------------------------
  // output side
  // ----------------------------------------------------------
  assign pop = (out_state_q == O_DROP) && !out.ack;  // ack fell, entry gone

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      out_state_q <= O_IDLE;
      out_req_q   <= 1'b0;
    end else begin
      unique case (out_state_q)
        O_IDLE: begin
          if (!empty && !out.ack) begin
            out_req_q   <= 1'b1;
            out_state_q <= O_REQ;
          end
        end
        O_REQ: begin
          if (out.ack) begin
            out_req_q   <= 1'b0;
            out_state_q <= O_DROP;
          end
        end
        O_DROP: begin
          if (pop) begin
            out_state_q <= O_IDLE;
          end
        end
        default: out_state_q <= O_IDLE;
      endcase
    end
  end

  // pointers and count, natural wrap at power-of-two depth
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop)  rd_ptr_q <= rd_ptr_q + 1'b1;
      unique case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;            // none or both
      endcase
    end
  end

  assign in.ack  = in_ack_q;
  assign out.req = out_req_q;
  assign out.pkt = mem_q[rd_ptr_q];  // head, stable until pop

endmodule

`default_nettype wire

// File: logic/int_exec_unit.sv
// Integer execute unit, the consumer of the operand path.
// Takes one packet at a time, computes add/sub/and/xor, strobes the
// result on CDB port 0 for one cycle and holds it on the writeback
// outputs until the four-phase writeback handshake completes.

`timescale 1ns/1ps
`default_nettype none

`include "prf_macros.svh"

module int_exec_unit import prf_pkg::*; (
  input  wire logic                  clk_i,
  input  wire logic                  rst_i,
  op_if.receiver                     in,
  output cdb_wr_t                    cdb_o,
  output logic                       wb_req_o,
  input  wire logic                  wb_ack_i,
  output logic [`PRF_TAG_W-1:0]      wb_dest_o,
  output logic [`PRF_XLEN-1:0]       wb_data_o
);

  typedef enum logic [1:0] {
    E_IDLE,  // waiting for a packet
    E_EXEC,  // packet held, result next edge
    E_WB,    // wb_req high
    E_DONE   // wb_req low, waiting for wb_ack low
  } exec_state_e;

  exec_state_e          state_q;
  logic                 in_ack_q;
  logic                 cdb_en_q;    // one-cycle strobe
  logic                 wb_req_q;
  operand_pkt_t         pkt_q;       // captured operands
  logic [`PRF_XLEN-1:0] result_q;

  // add and sub wrap at word width
  function automatic logic [`PRF_XLEN-1:0] alu(
    input alu_op_e              op,
    input logic [`PRF_XLEN-1:0] a,
    input logic [`PRF_XLEN-1:0] b
  );
    unique case (op)
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_AND:  return a & b;
      OP_XOR:  return a ^ b;
      default: return '0;
    endcase
  endfunction

  // ----------------------------------------------------------
  // control
  // ----------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q  <= E_IDLE;
      in_ack_q <= 1'b0;
      cdb_en_q <= 1'b0;
      wb_req_q <= 1'b0;
    end else begin
      cdb_en_q <= 1'b0;  // strobe, default low
      if (in_ack_q && !in.req) begin
        in_ack_q <= 1'b0;
      end
      unique case (state_q)
        E_IDLE: begin
          if (in.req && !in_ack_q) begin
            in_ack_q <= 1'b1;
            state_q  <= E_EXEC;
          end
        end
        E_EXEC: begin
          cdb_en_q <= 1'b1;
          wb_req_q <= 1'b1;
          state_q  <= E_WB;
        end
        E_WB: begin
          if (wb_ack_i) begin
            wb_req_q <= 1'b0;
            state_q  <= E_DONE;
          end
        end
        E_DONE: begin
          if (!wb_ack_i) state_q <= E_IDLE;
        end
        default: state_q <= E_IDLE;
      endcase
    end
  end

  // payload
  always_ff @(posedge clk_i) begin
    if ((state_q == E_IDLE) && in.req && !in_ack_q) begin
      pkt_q <= in.pkt;
    end
    if (state_q == E_EXEC) begin
      result_q <= alu(pkt_q.op, pkt_q.src_a, pkt_q.src_b);
    end
  end

  assign in.ack        = in_ack_q;
  assign cdb_o.wr_en   = cdb_en_q;
  assign cdb_o.wr_addr = pkt_q.dest;
  assign cdb_o.data_in = result_q;
  assign wb_req_o      = wb_req_q;
  assign wb_dest_o     = pkt_q.dest;  // held until next capture
  assign wb_data_o     = result_q;

endmodule

`default_nettype wire

// File: logic/prf_subsystem.sv
// Top level of the register-file operand path.
// Plain ports outside: issue handshake in, preload port, writeback
// handshake out. Inside: fetch -> queue -> execute, with the execute
// result fed back into the register file on CDB port 0.

`timescale 1ns/1ps
`default_nettype none

`include "prf_macros.svh"

module prf_subsystem import prf_pkg::*; (
  input  wire logic                   clk_i,
  input  wire logic                   rst_i,
  // issue
  input  wire logic                   issue_req_i,
  output logic                        issue_ack_o,
  input  wire alu_op_e                issue_op_i,
  input  wire logic [`PRF_TAG_W-1:0]  issue_dest_i,
  input  wire logic [`PRF_TAG_W-1:0]  issue_src_a_i,
  input  wire logic [`PRF_TAG_W-1:0]  issue_src_b_i,
  // preload, cdb port 1
  input  wire logic                   load_en_i,
  input  wire logic [`PRF_TAG_W-1:0]  load_addr_i,
  input  wire logic [`PRF_XLEN-1:0]   load_data_i,
  // writeback
  output logic                        wb_req_o,
  input  wire logic                   wb_ack_i,
  output logic [`PRF_TAG_W-1:0]       wb_dest_o,
  output logic [`PRF_XLEN-1:0]        wb_data_o
);

  prf_rd_req_t                  rd_req;
  prf_rd_rsp_t                  rd_rsp;
  cdb_wr_t                      exec_cdb;
  cdb_wr_t [`PRF_CDB_NUM-1:0]   cdb_bus;

  op_if fetch_to_queue ();
  op_if queue_to_exec ();

  // ----------------------------------------------------------
  // cdb ports
  // ----------------------------------------------------------
  assign cdb_bus[0]         = exec_cdb;
  assign cdb_bus[1].wr_en   = load_en_i;
  assign cdb_bus[1].wr_addr = load_addr_i;
  assign cdb_bus[1].data_in = load_data_i;

  prf_regfile u_prf_regfile (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .rd_req_i (rd_req),
    .rd_rsp_o (rd_rsp),
    .cdb_i    (cdb_bus)
  );

  operand_fetch u_operand_fetch (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .issue_req_i   (issue_req_i),
    .issue_ack_o   (issue_ack_o),
    .issue_op_i    (issue_op_i),
    .issue_dest_i  (issue_dest_i),
    .issue_src_a_i (issue_src_a_i),
    .issue_src_b_i (issue_src_b_i),
    .rd_req_o      (rd_req),
    .rd_rsp_i      (rd_rsp),
    .out           (fetch_to_queue.sender)
  );

  operand_queue #(
    .DEPTH (`PRF_QUEUE_DEPTH)
  ) u_operand_queue (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .in    (fetch_to_queue.receiver),
    .out   (queue_to_exec.sender)
  );

  int_exec_unit u_int_exec_unit (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .in        (queue_to_exec.receiver),
    .cdb_o     (exec_cdb),
    .wb_req_o  (wb_req_o),
    .wb_ack_i  (wb_ack_i),
    .wb_dest_o (wb_dest_o),
    .wb_data_o (wb_data_o)
  );

endmodule

`default_nettype wire

// File: verification/prf_subsystem_checker.sv
// Concurrent assertions for the operand path top level.
// Bound to prf_subsystem; watches the issue and writeback handshakes,
// the CDB port 0 strobe and the request/ack ordering.

`timescale 1ns/1ps
`default_nettype none

`include "prf_macros.svh"

module prf_subsystem_checker import prf_pkg::*; (
  input wire logic                  clk_i,
  input wire logic                  rst_i,
  input wire logic                  issue_req_i,
  input wire logic                  issue_ack_o,
  input wire alu_op_e               issue_op_i,
  input wire logic [`PRF_TAG_W-1:0] issue_dest_i,
  input wire logic [`PRF_TAG_W-1:0] issue_src_a_i,
  input wire logic [`PRF_TAG_W-1:0] issue_src_b_i,
  input wire logic                  wb_req_o,
  input wire logic                  wb_ack_i,
  input wire logic [`PRF_TAG_W-1:0] wb_dest_o,
  input wire logic [`PRF_XLEN-1:0]  wb_data_o,
  input wire logic                  cdb0_en_i   // exec result strobe
);

  // ----------------------------------------------------------
  // issue side
  // ----------------------------------------------------------
  issue_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    issue_req_i && !issue_ack_o |=> issue_req_i && $stable(issue_op_i)
      && $stable(issue_dest_i) && $stable(issue_src_a_i) && $stable(issue_src_b_i))
    else $error("issue request changed before ack");

  issue_order: assert property (@(posedge clk_i) disable iff (rst_i)
    $rose(issue_req_i) |-> !issue_ack_o)
    else $error("issue request rose with ack still high");

  // ----------------------------------------------------------
  // writeback side
  // ----------------------------------------------------------
  wb_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    wb_req_o && !wb_ack_i |=> $stable(wb_dest_o) && $stable(wb_data_o))
    else $error("writeback payload changed before ack");

  wb_order: assert property (@(posedge clk_i) disable iff (rst_i)
    $rose(wb_req_o) |-> !wb_ack_i)
    else $error("writeback request rose with ack still high");

  // one cdb strobe with each new writeback and none in between
  cdb_per_wb: assert property (@(posedge clk_i) disable iff (rst_i)
    cdb0_en_i == $rose(wb_req_o))
    else $error("cdb port 0 strobe does not match a new writeback");

endmodule

bind prf_subsystem prf_subsystem_checker u_prf_subsystem_checker (
  .clk_i         (clk_i),
  .rst_i         (rst_i),
  .issue_req_i   (issue_req_i),
  .issue_ack_o   (issue_ack_o),
  .issue_op_i    (issue_op_i),
  .issue_dest_i  (issue_dest_i),
  .issue_src_a_i (issue_src_a_i),
  .issue_src_b_i (issue_src_b_i),
  .wb_req_o      (wb_req_o),
  .wb_ack_i      (wb_ack_i),
  .wb_dest_o     (wb_dest_o),
  .wb_data_o     (wb_data_o),
  .cdb0_en_i     (exec_cdb.wr_en)
);

`default_nettype wire

// File: verification/prf_subsystem_tb.sv
// Testbench for the register-file operand path.
// Preloads registers, issues random and directed ops through the
// four-phase issue port, acks writebacks after random delays and
// checks every result in order against a register model.

`timescale 1ns/1ps
`default_nettype none

`include "prf_macros.svh"

module prf_subsystem_tb import prf_pkg::*; ();

  localparam int N_RANDOM = 40;
  localparam int N_SLOW   = 24;
  localparam int N_DIRECT = 4;
  localparam int TIMEOUT  = 40 * (N_RANDOM + N_SLOW + N_DIRECT) + 200;

  logic                  clk_i;
  logic                  rst_i;
  logic                  issue_req_i;
  logic                  issue_ack_o;
  alu_op_e               issue_op_i;
  logic [`PRF_TAG_W-1:0] issue_dest_i;
  logic [`PRF_TAG_W-1:0] issue_src_a_i;
  logic [`PRF_TAG_W-1:0] issue_src_b_i;
  logic                  load_en_i;
  logic [`PRF_TAG_W-1:0] load_addr_i;
  logic [`PRF_XLEN-1:0]  load_data_i;
  logic                  wb_req_o;
  logic                  wb_ack_i;
  logic [`PRF_TAG_W-1:0] wb_dest_o;
  logic [`PRF_XLEN-1:0]  wb_data_o;

  logic [31:0]           rng;      // issue stream
  logic [31:0]           ack_rng;  // writeback delay stream
  logic [`PRF_XLEN-1:0]  model_regs [`PRF_PHY_REG_NUM];
  int                    inflight [`PRF_PHY_REG_NUM];  // pending writes per reg
  logic [`PRF_TAG_W-1:0] exp_dest_q [$];
  logic [`PRF_XLEN-1:0]  exp_data_q [$];
  int                    errors;
  int                    issued;
  int                    results;
  int                    cycles;
  bit                    slow_wb;
  logic                  wb_prev;

  prf_subsystem u_prf_subsystem (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // expected result from the op definitions
  function automatic logic [`PRF_XLEN-1:0] ref_result(
    input alu_op_e              op,
    input logic [`PRF_XLEN-1:0] a,
    input logic [`PRF_XLEN-1:0] b
  );
    case (op)
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_AND:  return a & b;
      default: return a ^ b;
    endcase
  endfunction

  task automatic check_word(input string name, input logic [`PRF_XLEN-1:0] got,
                            input logic [`PRF_XLEN-1:0] exp);
    if (got !== exp) begin
      $display("Fail %0t %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_tag(input string name, input logic [`PRF_TAG_W-1:0] got,
                           input logic [`PRF_TAG_W-1:0] exp);
    if (got !== exp) begin
      $display("Fail %0t %s got %0d expected %0d", $time, name, got, exp);
      errors++;
    end
  endtask

  // ----------------------------------------------------------
  // stimulus tasks
  // ----------------------------------------------------------
  task automatic preload(input logic [`PRF_TAG_W-1:0] addr, input logic [`PRF_XLEN-1:0] data);
    @(posedge clk_i);
    load_en_i   <= 1'b1;
    load_addr_i <= addr;
    load_data_i <= data;
    if (addr != 0) model_regs[addr] = data;  // reg 0 stays zero
    @(posedge clk_i);
    load_en_i <= 1'b0;
  endtask

  // optional load in the issue cycle exercises forwarding
  task automatic issue_instr(input alu_op_e op, input logic [`PRF_TAG_W-1:0] dest,
                             input logic [`PRF_TAG_W-1:0] sa, input logic [`PRF_TAG_W-1:0] sb,
                             input bit with_load, input logic [`PRF_XLEN-1:0] ld_data);
    logic [`PRF_XLEN-1:0] res;
    if (with_load && sa != 0) model_regs[sa] = ld_data;
    res = ref_result(op, model_regs[sa], model_regs[sb]);
    exp_dest_q.push_back(dest);
    exp_data_q.push_back(res);
    if (dest != 0) begin
      model_regs[dest] = res;
      inflight[dest]++;
    end
    issued++;
    @(posedge clk_i);
    issue_req_i   <= 1'b1;
    issue_op_i    <= op;
    issue_dest_i  <= dest;
    issue_src_a_i <= sa;
    issue_src_b_i <= sb;
    if (with_load) begin
      load_en_i   <= 1'b1;
      load_addr_i <= sa;
      load_data_i <= ld_data;
    end
    @(posedge clk_i);
    load_en_i <= 1'b0;
    do @(negedge clk_i); while (!issue_ack_o);
    @(posedge clk_i);
    issue_req_i <= 1'b0;
    do @(negedge clk_i); while (issue_ack_o);
  endtask

  // source that no pending instruction will write
  task automatic pick_src(output logic [`PRF_TAG_W-1:0] src);
    src = '0;
    for (int t = 0; t < 8; t++) begin
      rng = xorshift(rng);
      if (inflight[rng[4:0]] == 0) begin
        src = rng[4:0];
        break;
      end
    end
  endtask

  task automatic random_issue();
    logic [`PRF_TAG_W-1:0] sa;
    logic [`PRF_TAG_W-1:0] sb;
    alu_op_e               op;
    logic [`PRF_TAG_W-1:0] dest;
    rng  = xorshift(rng);
    op   = alu_op_e'(rng[1:0]);
    dest = rng[12:8];
    pick_src(sa);
    pick_src(sb);
    issue_instr(op, dest, sa, sb, 1'b0, '0);
  endtask

  task automatic wait_drain();
    while (exp_dest_q.size() != 0) @(negedge clk_i);
    repeat (4) @(posedge clk_i);
  endtask

  // ----------------------------------------------------------
  // writeback ack after a random delay
  // ----------------------------------------------------------
  initial begin
    int delay;
    forever begin
      @(negedge clk_i);
      if (!rst_i && wb_req_o && !wb_ack_i) begin
        ack_rng = xorshift(ack_rng);
        delay   = slow_wb ? int'(ack_rng[3:0]) + 4 : int'(ack_rng[1:0] % 3);
        repeat (delay) @(posedge clk_i);
        @(posedge clk_i);
        wb_ack_i <= 1'b1;
        do @(negedge clk_i); while (wb_req_o);
        @(posedge clk_i);
        wb_ack_i <= 1'b0;
      end
    end
  end

  // compare each new writeback with the oldest expected result
  initial begin
    logic [`PRF_TAG_W-1:0] d;
    wb_prev = 1'b0;
    forever begin
      @(negedge clk_i);
      if (!rst_i && wb_req_o && !wb_prev) begin
        if (exp_dest_q.size() == 0) begin
          $display("Error: writeback arrived with no instruction outstanding at %0t", $time);
          errors++;
        end else begin
          d = exp_dest_q.pop_front();
          check_tag("wb_dest_o", wb_dest_o, d);
          check_word("wb_data_o", wb_data_o, exp_data_q.pop_front());
          if (d != 0) inflight[d]--;
        end
        results++;
      end
      wb_prev = wb_req_o;
    end
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= TIMEOUT) begin
      $display("Error: run did not finish within %0d cycles", TIMEOUT);
      $display("Simulation failed");
      $finish;
    end
  end

  // ----------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------
  initial begin
    rst_i = 1'b1;
    issue_req_i = 1'b0;
    issue_op_i = OP_ADD;
    issue_dest_i = '0;
    issue_src_a_i = '0;
    issue_src_b_i = '0;
    load_en_i = 1'b0;
    load_addr_i = '0;
    load_data_i = '0;
    wb_ack_i = 1'b0;
    rng = 32'h03b28561;
    ack_rng = 32'h03b28561;
    errors = 0;
    issued = 0;
    results = 0;
    cycles = 0;
    slow_wb = 1'b0;
    for (int r = 0; r < `PRF_PHY_REG_NUM; r++) begin
      model_regs[r] = '0;
      inflight[r]   = 0;
    end
    repeat (2) @(posedge clk_i);
    rst_i <= 1'b0;
    for (int r = 0; r < `PRF_PHY_REG_NUM; r++) begin
      rng = xorshift(rng);
      preload(r[`PRF_TAG_W-1:0], rng);  // reg 0 load must be ignored
    end
    issue_instr(OP_XOR, 5'd7, 5'd0, 5'd0, 1'b0, '0);   // zero source
    for (int i = 0; i < N_RANDOM; i++) random_issue();
    wait_drain();
    issue_instr(OP_ADD, 5'd5, 5'd3, 5'd4, 1'b0, '0);
    wait_drain();
    issue_instr(OP_SUB, 5'd6, 5'd5, 5'd3, 1'b0, '0);   // reads exec result
    wait_drain();
    issue_instr(OP_ADD, 5'd10, 5'd9, 5'd2, 1'b1, 32'h1234_5678);  // forwarded
    wait_drain();
    slow_wb = 1'b1;  // queue fills and issue stalls
    for (int i = 0; i < N_SLOW; i++) random_issue();
    wait_drain();
    // a repeated writeback would show up in this quiet window
    while (wb_req_o || wb_ack_i) @(negedge clk_i);
    repeat (16) @(negedge clk_i);
    if (results != issued) begin
      $display("Error: %0d instructions issued but %0d results seen", issued, results);
      errors++;
    end
    $display("errors: %0d  issued: %0d  results: %0d", errors, issued, results);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: prf_subsystem.f
+incdir+logic
logic/prf_pkg.sv
logic/op_if.sv
logic/prf_regfile.sv
logic/operand_fetch.sv
logic/operand_queue.sv
logic/int_exec_unit.sv
logic/prf_subsystem.sv
verification/prf_subsystem_checker.sv
verification/prf_subsystem_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the operand path simulation with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f prf_subsystem.f \
  --top-module prf_subsystem_tb -Mdir obj_dir -o prf_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

out=$(./obj_dir/prf_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulator exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "Simulation passed"; then
  exit 0
fi
exit 1
